//--- rtl/cache_defs.svh
// cache geometry

`ifndef CACHE_DEFS_SVH
`define CACHE_DEFS_SVH

// main array shape
`define NUM_SETS 8
`define NUM_WAYS 4
`define NUM_SET_BITS 3
`define NUM_WAY_BITS 2

// address tag width
`define NUM_TAG_BITS 10

// data word per line
`define LINE_BITS 64

// fully associative victim store
`define NUM_VICTIMS 4

`endif

//--- rtl/cache_pkg.sv
// cache types

`include "cache_defs.svh"

package cache_pkg;

	typedef struct packed {
		logic [`LINE_BITS-1:0] data;
		logic [`NUM_TAG_BITS-1:0] tag;
		logic valid;
		logic dirty;
	} cache_line_t;

	// one set, way 0 in the low bits
	typedef cache_line_t [`NUM_WAYS-1:0] cache_set_t;

	typedef struct packed {
		logic en;
		logic [`NUM_SET_BITS-1:0] idx;
		logic [`NUM_TAG_BITS-1:0] tag;
	} rd_req_t;

	typedef struct packed {
		logic en;
		logic [`NUM_SET_BITS-1:0] idx;
		logic [`NUM_TAG_BITS-1:0] tag;
		logic [`LINE_BITS-1:0] data;
		logic dirty;
	} wr_req_t;

	// displaced line, also used for writeback
	typedef struct packed {
		logic valid;
		logic [`NUM_SET_BITS-1:0] idx;
		cache_line_t line;
	} victim_t;

	typedef struct packed {
		logic valid;
		logic [`NUM_SET_BITS-1:0] idx;
		logic [`NUM_TAG_BITS-1:0] tag;
	} miss_t;

	typedef struct packed {
		logic valid;
		logic [`LINE_BITS-1:0] data;
		logic from_victim;
	} rd_resp_t;

endpackage

//--- rtl/tag_cam.sv
// set tag compare

`timescale 1ns/1ns

`include "cache_defs.svh"

module tag_cam (
	input logic [`NUM_WAYS-1:0][`NUM_TAG_BITS-1:0] set_tags,
	input logic [`NUM_WAYS-1:0] set_valid,
	input logic [`NUM_TAG_BITS-1:0] tag,
	output logic hit,
	output logic [`NUM_WAY_BITS-1:0] way
);

	logic [`NUM_WAYS-1:0] match;

	// only valid ways can hit
	always_comb begin
		for (int i = 0; i < `NUM_WAYS; i++) begin
			match[i] = set_valid[i] && (set_tags[i] == tag);
		end
	end

	// lowest matching way wins
	always_comb begin
		hit = |match;
		way = '0;
		for (int i = `NUM_WAYS - 1; i >= 0; i--) begin
			if (match[i]) begin
				way = `NUM_WAY_BITS'(i);
			end
		end
	end

endmodule

//--- rtl/plru_tree.sv
// tree pseudo-lru

`timescale 1ns/1ns

`include "cache_defs.svh"

module plru_tree (
	input logic clock,
	input logic reset,
	input logic rd_touch,
	input logic [`NUM_SET_BITS-1:0] rd_idx,
	input logic [`NUM_WAY_BITS-1:0] rd_way,
	input logic wr_touch,
	input logic [`NUM_SET_BITS-1:0] wr_idx,
	input logic [`NUM_WAY_BITS-1:0] wr_way,
	input logic [`NUM_SET_BITS-1:0] repl_idx,
	output logic [`NUM_WAY_BITS-1:0] repl_way
);

	// heap order, node n has children 2n+1 (left) and 2n+2 (right)
	logic [`NUM_SETS-1:0][`NUM_WAYS-2:0] bits;
	logic [`NUM_SETS-1:0][`NUM_WAYS-2:0] bits_next;

	// point every node on the path away from the touched way
	function automatic logic [`NUM_WAYS-2:0] touch(
		input logic [`NUM_WAYS-2:0] cur,
		input logic [`NUM_WAY_BITS-1:0] way
	);
		logic [`NUM_WAYS-2:0] res;
		int node;
		logic dir;

		res = cur;
		node = 0;
		for (int lvl = 0; lvl < `NUM_WAY_BITS; lvl++) begin
			dir = way[`NUM_WAY_BITS-1-lvl];
			res[node] = ~dir;
			node = 2 * node + 1 + int'(dir);
		end
		return res;
	endfunction

	// write touch lands on top of the read touch
	always_comb begin
		bits_next = bits;
		if (rd_touch) begin
			bits_next[rd_idx] = touch(bits_next[rd_idx], rd_way);
		end
		if (wr_touch) begin
			bits_next[wr_idx] = touch(bits_next[wr_idx], wr_way);
		end
	end

	// walk from the root, 0 goes left to the lower ways
	always_comb begin : repl_walk
		int node;
		logic dir;

		node = 0;
		repl_way = '0;
		for (int lvl = 0; lvl < `NUM_WAY_BITS; lvl++) begin
			dir = bits[repl_idx][node];
			repl_way[`NUM_WAY_BITS-1-lvl] = dir;
			node = 2 * node + 1 + int'(dir);
		end
	end

	always_ff @(posedge clock) begin
		if (reset) begin
			bits <= '0;
		end else begin
			bits <= bits_next;
		end
	end

endmodule

//--- rtl/cache_mem.sv
// main cache array

`timescale 1ns/1ns

`include "cache_defs.svh"

module cache_mem import cache_pkg::*; (
	input logic clock,
	input logic reset,
	input rd_req_t rd_req,
	input wr_req_t wr_req,
	output rd_resp_t main_resp,
	output miss_t rd_miss,
	output victim_t evict
);

	cache_set_t [`NUM_SETS-1:0] sets;

	logic [`NUM_WAYS-1:0][`NUM_TAG_BITS-1:0] rd_tags;
	logic [`NUM_WAYS-1:0][`NUM_TAG_BITS-1:0] wr_tags;
	logic [`NUM_WAYS-1:0] rd_valid;
	logic [`NUM_WAYS-1:0] wr_valid;

	logic rd_hit;
	logic wr_hit;
	logic [`NUM_WAY_BITS-1:0] rd_way;
	logic [`NUM_WAY_BITS-1:0] wr_way;
	logic [`NUM_WAY_BITS-1:0] repl_way;
	logic [`NUM_WAY_BITS-1:0] inv_way;
	logic [`NUM_WAY_BITS-1:0] fill_way;
	logic has_inv;
	logic fwd;

	for (genvar i = 0; i < `NUM_WAYS; i++) begin : g_way
		assign rd_tags[i] = sets[rd_req.idx][i].tag;
		assign rd_valid[i] = sets[rd_req.idx][i].valid;
		assign wr_tags[i] = sets[wr_req.idx][i].tag;
		assign wr_valid[i] = sets[wr_req.idx][i].valid;
	end

	tag_cam read_cam (
		.set_tags(rd_tags),
		.set_valid(rd_valid),
		.tag(rd_req.tag),
		.hit(rd_hit),
		.way(rd_way)
	);

	tag_cam write_cam (
		.set_tags(wr_tags),
		.set_valid(wr_valid),
		.tag(wr_req.tag),
		.hit(wr_hit),
		.way(wr_way)
	);

	plru_tree u_plru (
		.clock(clock),
		.reset(reset),
		.rd_touch(rd_req.en && rd_hit),
		.rd_idx(rd_req.idx),
		.rd_way(rd_way),
		.wr_touch(wr_req.en),
		.wr_idx(wr_req.idx),
		.wr_way(fill_way),
		.repl_idx(wr_req.idx),
		.repl_way(repl_way)
	);

	// lowest invalid way in the write set
	always_comb begin
		has_inv = ~&wr_valid;
		inv_way = '0;
		for (int i = `NUM_WAYS - 1; i >= 0; i--) begin
			if (!wr_valid[i]) begin
				inv_way = `NUM_WAY_BITS'(i);
			end
		end
	end

	always_comb begin
		if (wr_hit) begin
			fill_way = wr_way;
		end else if (has_inv) begin
			fill_way = inv_way;
		end else begin
			fill_way = repl_way;
		end
	end

	// same-cycle write to the read line wins
	assign fwd = rd_req.en && wr_req.en && (rd_req.idx == wr_req.idx) &&
		(rd_req.tag == wr_req.tag);

	always_comb begin
		main_resp.valid = fwd || (rd_req.en && rd_hit);
		main_resp.data = fwd ? wr_req.data : sets[rd_req.idx][rd_way].data;
		main_resp.from_victim = 1'b0;
	end

	always_comb begin
		rd_miss.valid = rd_req.en && !main_resp.valid;
		rd_miss.idx = rd_req.idx;
		rd_miss.tag = rd_req.tag;
	end

	// a miss into a full set pushes out a valid line
	always_comb begin
		evict.valid = wr_req.en && !wr_hit && !has_inv;
		evict.idx = wr_req.idx;
		evict.line = sets[wr_req.idx][fill_way];
	end

	always_ff @(posedge clock) begin
		if (reset) begin
			for (int s = 0; s < `NUM_SETS; s++) begin
				for (int w = 0; w < `NUM_WAYS; w++) begin
					sets[s][w].valid <= 1'b0;
				end
			end
		end else if (wr_req.en) begin
			sets[wr_req.idx][fill_way] <= '{
				data: wr_req.data,
				tag: wr_req.tag,
				valid: 1'b1,
				dirty: wr_req.dirty
			};
		end
	end

endmodule

//--- rtl/victim_cache.sv
// victim cache

`timescale 1ns/1ns

`include "cache_defs.svh"

module victim_cache import cache_pkg::*; (
	input logic clock,
	input logic reset,
	input wr_req_t wr_req,
	input rd_req_t rd_req,
	input rd_resp_t main_resp,
	input miss_t rd_miss,
	input victim_t evict,
	output rd_resp_t rd_resp,
	output miss_t miss,
	output victim_t writeback
);

	localparam int PTR_BITS = $clog2(`NUM_VICTIMS);

	logic [`NUM_VICTIMS-1:0][`NUM_SET_BITS-1:0] ent_idx;
	cache_line_t [`NUM_VICTIMS-1:0] ent_line;
	logic [PTR_BITS-1:0] wr_ptr;
	logic [PTR_BITS:0] count;

	logic [`NUM_VICTIMS-1:0] rd_match;
	logic [`NUM_VICTIMS-1:0] inval;
	logic [`LINE_BITS-1:0] hit_data;
	logic vhit;
	logic full;

	always_comb begin
		for (int i = 0; i < `NUM_VICTIMS; i++) begin
			rd_match[i] = ent_line[i].valid && (ent_idx[i] == rd_req.idx) &&
				(ent_line[i].tag == rd_req.tag);
			inval[i] = wr_req.en && ent_line[i].valid && (ent_idx[i] == wr_req.idx) &&
				(ent_line[i].tag == wr_req.tag);
		end
	end

	always_comb begin
		hit_data = ent_line[0].data;
		for (int i = `NUM_VICTIMS - 1; i >= 0; i--) begin
			if (rd_match[i]) begin
				hit_data = ent_line[i].data;
			end
		end
	end

	assign vhit = rd_req.en && (|rd_match);

	// array answer first, victim only on an array miss
	always_comb begin
		if (main_resp.valid) begin
			rd_resp = main_resp;
		end else begin
			rd_resp = '{valid: vhit, data: hit_data, from_victim: 1'b1};
		end
	end

	always_comb begin
		miss.valid = rd_miss.valid && !vhit;
		miss.idx = rd_miss.idx;
		miss.tag = rd_miss.tag;
	end

	assign full = (count == (PTR_BITS + 1)'(`NUM_VICTIMS));

	// oldest entry drops out, only dirty survivors go back
	always_comb begin
		writeback.valid = evict.valid && full && ent_line[wr_ptr].valid &&
			ent_line[wr_ptr].dirty && !inval[wr_ptr];
		writeback.idx = ent_idx[wr_ptr];
		writeback.line = ent_line[wr_ptr];
	end

	always_ff @(posedge clock) begin
		if (reset) begin
			for (int i = 0; i < `NUM_VICTIMS; i++) begin
				ent_line[i].valid <= 1'b0;
			end
			wr_ptr <= '0;
			count <= '0;
		end else begin
			for (int i = 0; i < `NUM_VICTIMS; i++) begin
				if (inval[i]) begin
					ent_line[i].valid <= 1'b0;
				end
			end
			if (evict.valid) begin
				ent_idx[wr_ptr] <= evict.idx;
				ent_line[wr_ptr] <= evict.line;
				wr_ptr <= wr_ptr + 1'b1;
				if (!full) begin
					count <= count + 1'b1;
				end
			end
		end
	end

endmodule

//--- rtl/cache_top.sv
// cache top level

`timescale 1ns/1ns

module cache_top import cache_pkg::*; (
	input logic clock,
	input logic reset,
	input rd_req_t rd_req,
	input wr_req_t wr_req,
	output rd_resp_t rd_resp,
	output miss_t miss,
	output victim_t writeback
);

	rd_resp_t main_resp;
	miss_t rd_miss;
	victim_t evict;

	cache_mem u_mem (
		.clock(clock),
		.reset(reset),
		.rd_req(rd_req),
		.wr_req(wr_req),
		.main_resp(main_resp),
		.rd_miss(rd_miss),
		.evict(evict)
	);

	// catches displaced lines and serves array misses
	victim_cache u_victim (
		.clock(clock),
		.reset(reset),
		.wr_req(wr_req),
		.rd_req(rd_req),
		.main_resp(main_resp),
		.rd_miss(rd_miss),
		.evict(evict),
		.rd_resp(rd_resp),
		.miss(miss),
		.writeback(writeback)
	);

endmodule

//--- tb/cache_tb.sv
// cache testbench

`timescale 1ns/1ns

`include "cache_defs.svh"

module cache_tb import cache_pkg::*; ();

	localparam int MAX_CYCLES = 4000;

	logic clock;
	logic reset;
	rd_req_t rd_req;
	wr_req_t wr_req;
	rd_resp_t rd_resp;
	miss_t miss;
	victim_t writeback;

	// reference model
	cache_line_t m_sets [`NUM_SETS][`NUM_WAYS];
	logic [`NUM_WAYS-2:0] m_tree [`NUM_SETS];
	logic [`NUM_SET_BITS-1:0] v_idx [`NUM_VICTIMS];
	cache_line_t v_line [`NUM_VICTIMS];
	int v_ptr;
	int v_count;

	int cycles;
	int checks;
	int errors;
	int test_base;
	int wb_seen;

	cache_top u_dut (
		.clock(clock),
		.reset(reset),
		.rd_req(rd_req),
		.wr_req(wr_req),
		.rd_resp(rd_resp),
		.miss(miss),
		.writeback(writeback)
	);

	initial begin
		clock = 1'b0;
		forever #4 clock = ~clock;
	end

	always @(posedge clock) begin
		cycles++;
		if (cycles > MAX_CYCLES) begin
			$display("timeout: the run did not finish within %0d cycles", MAX_CYCLES);
			$display("** FAIL **");
			$finish;
		end
	end

	function automatic int find_way(logic [`NUM_SET_BITS-1:0] idx,
		logic [`NUM_TAG_BITS-1:0] tag);
		for (int w = 0; w < `NUM_WAYS; w++) begin
			if (m_sets[idx][w].valid && m_sets[idx][w].tag == tag) begin
				return w;
			end
		end
		return -1;
	endfunction

	function automatic int find_entry(logic [`NUM_SET_BITS-1:0] idx,
		logic [`NUM_TAG_BITS-1:0] tag);
		for (int i = 0; i < `NUM_VICTIMS; i++) begin
			if (v_line[i].valid && v_idx[i] == idx && v_line[i].tag == tag) begin
				return i;
			end
		end
		return -1;
	endfunction

	// root picks a half, then one node per pair
	task automatic touch_tree(logic [`NUM_SET_BITS-1:0] idx, int w);
		m_tree[idx][0] = (w < 2);
		if (w < 2) begin
			m_tree[idx][1] = (w == 0);
		end else begin
			m_tree[idx][2] = (w == 2);
		end
	endtask

	// a 0 bit leads to the lower ways
	function automatic int tree_way(logic [`NUM_SET_BITS-1:0] idx);
		if (m_tree[idx][0]) begin
			return m_tree[idx][2] ? 3 : 2;
		end
		return m_tree[idx][1] ? 1 : 0;
	endfunction

	function automatic logic [`LINE_BITS-1:0] line_data(int idx, int tag, int salt);
		return {16'(salt), 16'(tag), 16'(idx), 16'hc0de};
	endfunction

	function automatic rd_req_t read_req(int idx, int tag);
		return rd_req_t'{1'b1, `NUM_SET_BITS'(idx), `NUM_TAG_BITS'(tag)};
	endfunction

	function automatic wr_req_t write_req(int idx, int tag, logic [`LINE_BITS-1:0] data,
		logic dirty);
		return wr_req_t'{1'b1, `NUM_SET_BITS'(idx), `NUM_TAG_BITS'(tag), data, dirty};
	endfunction

	// compare this cycle's outputs, then advance the model past the edge
	task automatic check_cycle();
		int rw;
		int ww;
		int vi;
		int fill;
		logic exp_valid;
		logic exp_fv;
		logic exp_miss;
		logic exp_wb;
		logic evict;
		logic [`LINE_BITS-1:0] exp_data;
		logic [`NUM_VICTIMS-1:0] inval;
		cache_line_t old;

		rw = rd_req.en ? find_way(rd_req.idx, rd_req.tag) : -1;
		vi = rd_req.en ? find_entry(rd_req.idx, rd_req.tag) : -1;
		exp_valid = 1'b1;
		exp_fv = 1'b0;
		exp_data = '0;
		if (rd_req.en && wr_req.en && rd_req.idx == wr_req.idx && rd_req.tag == wr_req.tag) begin
			exp_data = wr_req.data;
		end else if (rw >= 0) begin
			exp_data = m_sets[rd_req.idx][rw].data;
		end else if (vi >= 0) begin
			exp_data = v_line[vi].data;
			exp_fv = 1'b1;
		end else begin
			exp_valid = 1'b0;
		end
		exp_miss = rd_req.en && !exp_valid;

		ww = find_way(wr_req.idx, wr_req.tag);
		fill = -1;
		for (int w = `NUM_WAYS - 1; w >= 0; w--) begin
			if (!m_sets[wr_req.idx][w].valid) begin
				fill = w;
			end
		end
		evict = wr_req.en && ww < 0 && fill < 0;
		if (ww >= 0) begin
			fill = ww;
		end else if (fill < 0) begin
			fill = tree_way(wr_req.idx);
		end
		old = m_sets[wr_req.idx][fill];
		for (int i = 0; i < `NUM_VICTIMS; i++) begin
			inval[i] = wr_req.en && v_line[i].valid && v_idx[i] == wr_req.idx &&
				v_line[i].tag == wr_req.tag;
		end
		exp_wb = evict && v_count == `NUM_VICTIMS && v_line[v_ptr].valid &&
			v_line[v_ptr].dirty && !inval[v_ptr];

		checks += 3;
		assert (rd_resp.valid == exp_valid && (!exp_valid ||
			(rd_resp.data == exp_data && rd_resp.from_victim == exp_fv))) else begin
			$display("mismatch at %0t: read %0d/%0h gave %b %h %b, expected %b %h %b",
				$time, rd_req.idx, rd_req.tag, rd_resp.valid, rd_resp.data,
				rd_resp.from_victim, exp_valid, exp_data, exp_fv);
			errors++;
		end
		assert (miss.valid == exp_miss && (!exp_miss ||
			(miss.idx == rd_req.idx && miss.tag == rd_req.tag))) else begin
			$display("mismatch at %0t: miss %b %0d/%0h, expected %b %0d/%0h", $time,
				miss.valid, miss.idx, miss.tag, exp_miss, rd_req.idx, rd_req.tag);
			errors++;
		end
		assert (writeback.valid == exp_wb && (!exp_wb ||
			(writeback.idx == v_idx[v_ptr] && writeback.line == v_line[v_ptr]))) else begin
			$display("mismatch at %0t: writeback %b %0d/%0h, expected %b %0d/%0h", $time,
				writeback.valid, writeback.idx, writeback.line.tag, exp_wb,
				v_idx[v_ptr], v_line[v_ptr].tag);
			errors++;
		end
		wb_seen += int'(writeback.valid);

		if (rd_req.en && rw >= 0) begin
			touch_tree(rd_req.idx, rw);
		end
		for (int i = 0; i < `NUM_VICTIMS; i++) begin
			if (inval[i]) begin
				v_line[i].valid = 1'b0;
			end
		end
		// new victim lands on the oldest slot
		if (evict) begin
			v_idx[v_ptr] = wr_req.idx;
			v_line[v_ptr] = old;
			v_ptr = (v_ptr + 1) % `NUM_VICTIMS;
			if (v_count < `NUM_VICTIMS) begin
				v_count++;
			end
		end
		if (wr_req.en) begin
			m_sets[wr_req.idx][fill] = cache_line_t'{wr_req.data, wr_req.tag, 1'b1,
				wr_req.dirty};
			touch_tree(wr_req.idx, fill);
		end
	endtask

	task automatic run_cycle(rd_req_t r, wr_req_t w);
		@(negedge clock);
		rd_req = r;
		wr_req = w;
		#3;
		check_cycle();
	endtask

	task automatic report_test(string name);
		$display("%s: %0d errors", name, errors - test_base);
		test_base = errors;
	endtask

	initial begin
		int dtag;
		int wb_start;
		rd_req_t r;
		wr_req_t w;

		void'($urandom(32'hb621));
		reset = 1'b1;
		rd_req = '0;
		wr_req = '0;
		for (int s = 0; s < `NUM_SETS; s++) begin
			m_tree[s] = '0;
			for (int k = 0; k < `NUM_WAYS; k++) begin
				m_sets[s][k].valid = 1'b0;
			end
		end
		for (int i = 0; i < `NUM_VICTIMS; i++) begin
			v_line[i].valid = 1'b0;
		end
		v_ptr = 0;
		v_count = 0;
		repeat (16) @(posedge clock);
		@(negedge clock);
		reset = 1'b0;

		repeat (2) run_cycle('0, '0);
		for (int s = 0; s < `NUM_SETS; s++) begin
			run_cycle(read_req(s, 5), '0);
		end
		run_cycle('0, write_req(3, 'h12, line_data(3, 'h12, 1), 1'b0));
		repeat (2) run_cycle(read_req(3, 'h12), '0);
		report_test("reset and basic hits");

		run_cycle(read_req(2, 'h40), write_req(2, 'h40, line_data(2, 'h40, 1), 1'b1));
		run_cycle(read_req(2, 'h40), write_req(2, 'h41, line_data(2, 'h41, 1), 1'b0));
		run_cycle(read_req(2, 'h41), '0);
		report_test("forwarding");

		// ways 0 to 3 of set 5, then one more tag
		for (int t = 0; t < 4; t++) begin
			run_cycle(read_req(5, 'h103 - t), write_req(5, 'h100 + t,
				line_data(5, 'h100 + t, 1), t[0]));
		end
		run_cycle(read_req(5, 'h102), '0);
		run_cycle(read_req(5, 'h100), '0);
		run_cycle('0, write_req(5, 'h104, line_data(5, 'h104, 1), 1'b1));
		for (int t = 0; t < 5; t++) begin
			run_cycle(read_req(5, 'h100 + t), '0);
		end
		report_test("fill and replacement");

		dtag = 'h100;
		for (int t = 0; t < 4; t++) begin
			if (find_way(5, 'h100 + t) < 0) begin
				dtag = 'h100 + t;
			end
		end
		run_cycle(read_req(5, dtag), '0);
		run_cycle(read_req(5, dtag), write_req(5, dtag, line_data(5, dtag, 2), 1'b0));
		run_cycle(read_req(5, dtag), '0);
		report_test("victim service and invalidation");

		wb_start = wb_seen;
		for (int t = 0; t < 12; t++) begin
			run_cycle(read_req(6, 'h1fd + t), write_req(6, 'h200 + t,
				line_data(6, 'h200 + t, 3), t[0]));
		end
		assert (wb_seen > wb_start) else begin
			$display("victim overflow produced no writeback pulse at all");
			errors++;
		end
		report_test("victim overflow");

		// two sets and six tags keep the victim cache busy
		for (int n = 0; n < 1800; n++) begin
			r = read_req(($urandom % 2) ? 7 : 1, 'h300 + $urandom % 6);
			r.en = ($urandom % 4) != 0;
			w = write_req(($urandom % 2) ? 7 : 1, 'h300 + $urandom % 6,
				{$urandom, $urandom}, 1'($urandom % 2));
			w.en = ($urandom % 2) != 0;
			run_cycle(r, w);
		end
		report_test("random mix");

		$display("checks %0d, errors %0d, writebacks %0d", checks, errors, wb_seen);
		if (errors == 0) begin
			$display("** PASS **");
		end else begin
			$display("** FAIL **");
		end
		$finish;
	end

endmodule

//--- project.f
+incdir+rtl
rtl/cache_pkg.sv
rtl/tag_cam.sv
rtl/plru_tree.sv
rtl/cache_mem.sv
rtl/victim_cache.sv
rtl/cache_top.sv
tb/cache_tb.sv

//--- run.sh
#!/bin/sh
# compile and run the cache testbench with Verilator
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert -Wno-fatal --top-module cache_tb -f project.f \
	-Mdir obj_dir -o cache_sim > build.log 2>&1 || { cat build.log; exit 1; }
./obj_dir/cache_sim > sim.log 2>&1 || echo "simulator exited with an error"
cat sim.log
grep -qxF '** PASS **' sim.log && echo "simulation passed" || { echo "simulation failed"; exit 1; }
